//--- source/clk_regmap_pkg.sv
//////////////////////////////
// clock enable register map
// APB address width, register
// offsets and control bit
// positions of the block
//////////////////////////////

`default_nettype none

package clk_regmap_pkg;

  // byte addresses, 32-bit registers
  localparam int apb_addr_w = 8;

  // enable bit, reads back as stored
  localparam logic [apb_addr_w-1:0] reg_ctrl = 8'h00;
  // write 1 to clear the edge counter, reads as zero
  localparam logic [apb_addr_w-1:0] reg_cmd = 8'h04;
  // read only edge count
  localparam logic [apb_addr_w-1:0] reg_count = 8'h08;

  // bit positions
  localparam int ctrl_en_bit = 0;
  localparam int cmd_clear_bit = 0;

endpackage : clk_regmap_pkg

`default_nettype wire

//--- source/clk_types_pkg.sv
//////////////////////////////
// clock enable data types
// vector widths shared by the
// divider, register block and
// edge counter, plus the gate
// state encoding
//////////////////////////////

`default_nettype none

package clk_types_pkg;

  // APB read and write data
  typedef logic [31:0] apb_data_t;

  // rising edges seen on the gated clock
  typedef logic [31:0] edge_count_t;

  // reference clock division ratio, even and at least 2
  typedef logic [7:0] div_ratio_t;

  // glitch-free gate, all moves happen while the divided clock is low
  typedef enum logic [1:0] {
    // gate closed, output held low
    gate_off   = 2'b00,
    // enable seen, wait one low phase before opening
    gate_arm   = 2'b01,
    // gate open, divided clock passes
    gate_on    = 2'b10,
    // enable dropped, gate closed, can reopen without arming
    gate_drain = 2'b11
  } gate_state_t;

endpackage : clk_types_pkg

`default_nettype wire

//--- source/clock_div.sv
//////////////////////////////
// reference clock divider
// brings counter_reset into the
// reference domain and divides
// clk_ref by an even ratio
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_div #(
  parameter clk_types_pkg::div_ratio_t div_ratio = 8'd2
) (
  input  logic clk_ref,
  input  logic counter_reset,
  output logic clk_div,
  output logic ref_reset
);

  import clk_types_pkg::*;

  // toggle after half the ratio in reference cycles
  localparam div_ratio_t last_cnt = (div_ratio >> 1) - 8'd1;

  logic       rst_meta;
  div_ratio_t half_cnt;

  // two stage reset synchronizer
  always_ff @(posedge clk_ref) begin
    rst_meta  <= counter_reset;
    ref_reset <= rst_meta;
  end

  // divided clock held low during reset, first rise half a ratio after release
  always_ff @(posedge clk_ref) begin
    if (ref_reset) begin
      half_cnt <= '0;
      clk_div  <= 1'b0;
    end else if (half_cnt == last_cnt) begin
      half_cnt <= '0;
      clk_div  <= ~clk_div;
    end else begin
      half_cnt <= half_cnt + 8'd1;
    end
  end

  // an odd ratio would give an uneven duty cycle
  ratio_even_a: assert property (
    @(posedge clk_ref) (div_ratio >= 8'd2) && (div_ratio[0] == 1'b0)
  ) else $error("div_ratio must be even and at least 2");

endmodule : clock_div

`default_nettype wire

//--- source/clock_en_control.sv
//////////////////////////////
// clock enable control
// APB registers for enable,
// counter clear and edge count
// readback, and the glitch-free
// gate on the divided clock
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_en_control (
  input  logic                                 clk50,
  input  logic                                 counter_reset,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [clk_regmap_pkg::apb_addr_w-1:0] paddr,
  input  clk_types_pkg::apb_data_t             pwdata,
  output clk_types_pkg::apb_data_t             prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  logic                                 clk_div,
  input  logic                                 ref_reset,
  input  clk_types_pkg::edge_count_t           edge_count,
  output logic                                 count_clear,
  output logic                                 clk_out
);

  import clk_regmap_pkg::*;
  import clk_types_pkg::*;

  logic        apb_access;
  logic        wr_access;
  logic        addr_valid;
  logic        en_reg;
  logic        en_meta;
  logic        en_sync;
  logic        gate_open;
  gate_state_t gate_state;
  gate_state_t gate_next;

  // no wait states so every access finishes in its access cycle
  assign pready     = 1'b1;
  assign apb_access = psel & penable;
  assign wr_access  = apb_access & pwrite;
  assign addr_valid = (paddr == reg_ctrl) || (paddr == reg_cmd) || (paddr == reg_count);
  assign pslverr    = apb_access & ~addr_valid;

  // enable register and one cycle clear pulse
  always_ff @(posedge clk50) begin
    if (counter_reset) begin
      en_reg      <= 1'b0;
      count_clear <= 1'b0;
    end else begin
      if (wr_access && (paddr == reg_ctrl)) begin
        en_reg <= pwdata[ctrl_en_bit];
      end
      count_clear <= wr_access && (paddr == reg_cmd) && pwdata[cmd_clear_bit];
    end
  end

  // cmd and unmapped addresses read zero
  always_comb begin
    prdata = '0;
    case (paddr)
      reg_ctrl:  prdata[ctrl_en_bit] = en_reg;
      reg_count: prdata = edge_count;
      default:   prdata = '0;
    endcase
  end

  // gate moves
  always_comb begin
    gate_next = gate_state;
    case (gate_state)
      gate_off:   if (en_sync) gate_next = gate_arm;
      gate_arm:   gate_next = en_sync ? gate_on : gate_off;
      gate_on:    if (!en_sync) gate_next = gate_drain;
      gate_drain: gate_next = en_sync ? gate_on : gate_off;
      default:    gate_next = gate_off;
    endcase
  end

  // clocked on the falling edge of clk_div so the gate only changes while the clock is low
  always_ff @(negedge clk_div) begin
    if (ref_reset) begin
      en_meta    <= 1'b0;
      en_sync    <= 1'b0;
      gate_state <= gate_off;
      gate_open  <= 1'b0;
    end else begin
      en_meta    <= en_reg;
      en_sync    <= en_meta;
      gate_state <= gate_next;
      gate_open  <= (gate_next == gate_on);
    end
  end

  // whole high pulses only
  assign clk_out = clk_div & gate_open;

  // address and direction held from setup into the access cycle
  apb_stable_a: assert property (
    @(posedge clk50) disable iff (counter_reset)
    (psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite))
  ) else $error("APB setup not followed by a stable access cycle");

endmodule : clock_en_control

`default_nettype wire

//--- source/clk_edge_counter.sv
//////////////////////////////
// gated clock edge counter
// samples the gated clock in
// clk50 and counts its rising
// edges, clear has priority
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clk_edge_counter (
  input  logic                       clk50,
  input  logic                       counter_reset,
  input  logic                       clk_gated,
  input  logic                       count_clear,
  output clk_types_pkg::edge_count_t edge_count
);

  logic gated_meta;
  logic gated_sync;
  logic gated_prev;
  logic gated_rise;

  // two stage synchronizer plus a delayed copy for edge detect
  always_ff @(posedge clk50) begin
    if (counter_reset) begin
      gated_meta <= 1'b0;
      gated_sync <= 1'b0;
      gated_prev <= 1'b0;
    end else begin
      gated_meta <= clk_gated;
      gated_sync <= gated_meta;
      gated_prev <= gated_sync;
    end
  end

  assign gated_rise = gated_sync & ~gated_prev;

  // count lands 3 clk50 cycles after the edge
  always_ff @(posedge clk50) begin
    if (counter_reset) begin
      edge_count <= '0;
    end else if (count_clear) begin
      edge_count <= '0;
    end else if (gated_rise) begin
      edge_count <= edge_count + 32'd1;
    end
  end

  // a nonzero count only returns to zero through clear or reset
  no_wrap_a: assert property (
    @(posedge clk50) disable iff (counter_reset)
    (edge_count != '0) && !count_clear |=> (edge_count != '0)
  ) else $error("edge_count wrapped to zero");

endmodule : clk_edge_counter

`default_nettype wire

//--- source/clock_en_top.sv
//////////////////////////////
// clock enable subsystem top
// divider, APB control with
// clock gate, and edge counter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_en_top #(
  parameter clk_types_pkg::div_ratio_t div_ratio = 8'd2
) (
  input  logic                                 clk50,
  input  logic                                 counter_reset,
  input  logic                                 clk_ref,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [clk_regmap_pkg::apb_addr_w-1:0] paddr,
  input  clk_types_pkg::apb_data_t             pwdata,
  output clk_types_pkg::apb_data_t             prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  output logic                                 clk_out
);

  import clk_types_pkg::*;

  logic        clk_div;
  logic        ref_reset;
  logic        count_clear;
  edge_count_t edge_count;

  clock_div #(
    .div_ratio (div_ratio)
  ) u_clock_div (
    .clk_ref       (clk_ref),
    .counter_reset (counter_reset),
    .clk_div       (clk_div),
    .ref_reset     (ref_reset)
  );

  clock_en_control u_clock_en_control (
    .clk50         (clk50),
    .counter_reset (counter_reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .clk_div       (clk_div),
    .ref_reset     (ref_reset),
    .edge_count    (edge_count),
    .count_clear   (count_clear),
    .clk_out       (clk_out)
  );

  // counts the same gated clock that leaves the block
  clk_edge_counter u_clk_edge_counter (
    .clk50         (clk50),
    .counter_reset (counter_reset),
    .clk_gated     (clk_out),
    .count_clear   (count_clear),
    .edge_count    (edge_count)
  );

endmodule : clock_en_top

`default_nettype wire

//--- verification/clock_en_tb_tasks.svh
//////////////////////////////
// clock enable testbench tasks
// APB transfers, typed compares
// and bounded waits
//////////////////////////////

// one APB transfer with the response taken mid access cycle
task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                          input apb_data_t wdata, output apb_data_t rdata, output logic err);
  int waited;
  waited = 0;
  @(posedge clk50);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk50);
  penable <= 1'b1;
  @(negedge clk50);
  while (pready !== 1'b1 && waited < 16) begin
    @(negedge clk50);
    waited++;
  end
  if (pready !== 1'b1) report_timeout("pready");
  rdata = prdata;
  err   = pslverr;
  @(posedge clk50);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic report_value(input string name, input string got_s, input string exp_s);
  errors++;
  $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got_s, exp_s);
endtask

task automatic report_timeout(input string what);
  errors++;
  $display("ERROR: t=%0t timed out waiting for %s", $time, what);
endtask

task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
  checks++;
  if (got !== exp) report_value(name, $sformatf("0x%08h", got), $sformatf("0x%08h", exp));
endtask

task automatic check_count(input string name, input edge_count_t got, input edge_count_t exp);
  checks++;
  if (got !== exp) report_value(name, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

task automatic check_err(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) report_value(name, $sformatf("%b", got), $sformatf("%b", exp));
endtask

// n more rising or falling edges of clk_out
task automatic wait_edges(input logic rising, input int n, input string what);
  int target;
  int waited;
  target = (rising ? rise_total : fall_total) + n;
  waited = 0;
  while ((rising ? rise_total : fall_total) < target && waited < 40 + 10 * n) begin
    @(posedge clk50);
    waited++;
  end
  if ((rising ? rise_total : fall_total) < target) report_timeout(what);
endtask

// clk_out low for 8 clk50 cycles in a row
task automatic wait_quiet();
  int low_run;
  int waited;
  low_run = 0;
  waited = 0;
  while (low_run < 8 && waited < 200) begin
    @(negedge clk50);
    low_run = (clk_out === 1'b0) ? low_run + 1 : 0;
    waited++;
  end
  if (low_run < 8) report_timeout("clk_out to stay low");
endtask

//--- verification/clock_en_tb.sv
//////////////////////////////
// clock enable testbench
// random APB traffic checked
// against a model of the enable
// bit and the clk_out edges
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_en_tb;

  import clk_regmap_pkg::*;
  import clk_types_pkg::*;

  localparam div_ratio_t div_ratio = 8'd2;
  localparam int ref_period = 230;

  logic clk50 = 1'b0;
  logic clk_ref = 1'b0;
  logic counter_reset, psel, penable, pwrite, pready, pslverr, clk_out;
  logic [apb_addr_w-1:0] paddr, addr_rand;
  apb_data_t pwdata, prdata, rdata, wval, first_count;
  logic err, model_en;
  integer seed;
  int errors = 0, checks = 0, tests = 0, test_errors = 0;
  int model_edges = 0, rise_total = 0, fall_total = 0, n;
  time rise_time, fall_time;

  always #50 clk50 = ~clk50;
  always #(ref_period / 2) clk_ref = ~clk_ref;

  clock_en_top #(.div_ratio(div_ratio)) u_clock_en_top (.*);

  // edge model taken straight at the DUT port
  always @(posedge clk_out) begin
    rise_total++;
    model_edges++;
    rise_time = $time;
  end

  always @(negedge clk_out) begin
    fall_total++;
    fall_time = $time;
  end

  `include "clock_en_tb_tasks.svh"

  task automatic set_enable(input logic en);
    model_en = en;
    apb_access(1'b1, reg_ctrl, apb_data_t'(en) << ctrl_en_bit, rdata, err);
  endtask

  // call only while clk_out is quiet and no edge is in flight
  task automatic clear_count();
    model_edges = 0;
    apb_access(1'b1, reg_cmd, apb_data_t'(1) << cmd_clear_bit, rdata, err);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_errors) ? "ok" : "errors seen");
    test_errors = errors;
  endtask

  initial begin
    seed = 2742;
    counter_reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    model_en = 1'b0;
    repeat (2) @(posedge clk50);
    counter_reset <= 1'b0;

    apb_access(1'b0, reg_ctrl, '0, rdata, err);
    check_data("prdata ctrl", rdata, '0);
    apb_access(1'b0, reg_count, '0, rdata, err);
    check_count("prdata count", rdata, '0);
    n = rise_total;
    repeat (20) @(posedge clk_ref);
    @(negedge clk50);
    check_count("clk_out rises", rise_total - n, '0);
    check_err("clk_out", clk_out, 1'b0);
    end_test("reset state");

    // only the enable bit is stored
    wval = $random(seed);
    model_en = wval[ctrl_en_bit];
    apb_access(1'b1, reg_ctrl, wval, rdata, err);
    check_err("pslverr", err, 1'b0);
    apb_access(1'b0, reg_ctrl, '0, rdata, err);
    check_data("prdata ctrl", rdata, apb_data_t'(model_en) << ctrl_en_bit);
    // a value written to cmd never reads back
    wval = $random(seed);
    apb_access(1'b1, reg_cmd, wval, rdata, err);
    apb_access(1'b0, reg_cmd, '0, rdata, err);
    check_data("prdata cmd", rdata, '0);
    repeat (4) begin
      addr_rand = 8'd12 + ($unsigned($random(seed)) % 244);
      apb_access(1'b0, addr_rand, '0, rdata, err);
      check_err("pslverr", err, 1'b1);
    end
    apb_access(1'b0, reg_count, '0, rdata, err);
    check_err("pslverr", err, 1'b0);
    set_enable(1'b0);
    wait_quiet();
    end_test("register access");

    set_enable(1'b1);
    wait_edges(1'b1, 1, "first clk_out rise");
    repeat (3) begin
      wait_edges(1'b0, 1, "clk_out fall");
      check_count("clk_out high ref cycles", (fall_time - rise_time) / ref_period, div_ratio / 2);
      wait_edges(1'b1, 1, "clk_out rise");
      check_count("clk_out low ref cycles", (rise_time - fall_time) / ref_period, div_ratio / 2);
    end
    set_enable(1'b0);
    wait_quiet();
    end_test("gated clock pulses");

    clear_count();
    set_enable(1'b1);
    n = 5 + ($unsigned($random(seed)) % 16);
    wait_edges(1'b1, n, "clk_out edges");
    set_enable(1'b0);
    wait_quiet();
    repeat (5) @(posedge clk50);
    apb_access(1'b0, reg_count, '0, rdata, err);
    check_count("prdata count", rdata, model_edges);
    end_test("edge count");

    // count holds while the gate is closed
    apb_access(1'b0, reg_count, '0, first_count, err);
    repeat (3 + ($unsigned($random(seed)) % 16)) @(posedge clk50);
    apb_access(1'b0, reg_count, '0, rdata, err);
    check_count("prdata count", rdata, first_count);
    // clear lands before the first edge of the new enable
    set_enable(1'b1);
    clear_count();
    apb_access(1'b0, reg_count, '0, rdata, err);
    check_count("prdata count", rdata, '0);
    set_enable(1'b0);
    wait_quiet();
    end_test("freeze and clear");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : clock_en_tb

`default_nettype wire

//--- verilog.f
+incdir+verification
source/clk_regmap_pkg.sv
source/clk_types_pkg.sv
source/clock_div.sv
source/clock_en_control.sv
source/clk_edge_counter.sv
source/clock_en_top.sv
verification/clock_en_tb.sv
